/* vlog.f */
+incdir+design
design/uart_pkg.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_rx_fifo.sv
design/uart_core.sv
verification/tb_uart_core.sv

/* verification/tb_uart_core.sv */
////////////////////////////////////////
// UART core testbench
// Loopback and bit-banged line tests with
// a scoreboard, assertions and a watchdog
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "uart_cfg.svh"

module tb_uart_core;
    import uart_pkg::*;

    localparam int unsigned  B     = `UART_CLKS_PER_BIT;
    localparam int unsigned  DEPTH = `UART_FIFO_DEPTH;
    localparam int unsigned  FRAME = 11 * B;               // Longest frame in clocks
    localparam uart_parity_e PAR   = `UART_PARITY;
    localparam longint       WATCHDOG_NS = 400_000;        // 60 frames need about 211 us

    logic                       clk;
    logic                       rst;
    logic [`UART_DATA_BITS-1:0] tx_data;
    logic                       tx_valid;
    logic                       tx_ready;
    logic                       tx;
    logic                       rx_line;
    uart_char_t                 rx_char;
    logic                       rx_valid;
    logic                       rx_ready;
    logic                       rx_overrun;
    logic                       bb_line;       // Bit-banged serial line
    logic                       loopback;      // Selects tx as the rx source
    logic [31:0]                rnd_state;
    uart_char_t                 exp_q [$];     // Scoreboard
    int                         err_count;
    int                         test_errs;
    int                         pass_count;
    int                         fail_count;
    int                         overrun_count;

    assign rx_line = loopback ? tx : bb_line;

    uart_core dut_i (
        .clk        (clk),
        .rst        (rst),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .tx         (tx),
        .rx         (rx_line),
        .rx_char    (rx_char),
        .rx_valid   (rx_valid),
        .rx_ready   (rx_ready),
        .rx_overrun (rx_overrun)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: tests did not finish");
        $display("TEST FAIL");
        $finish;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////
    task automatic report_fail(input string msg);
        $display("[FAIL] %0d ns: %s", $time, msg);
        err_count++;
    endtask

    task automatic tick();
        @(posedge clk);
        #2;                                    // Drive and sample off the edge
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) tick();
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [`UART_DATA_BITS-1:0] next_byte();
        rnd_state = xorshift32(rnd_state);
        return rnd_state[`UART_DATA_BITS-1:0];
    endfunction

    // Even parity makes the ones count even, odd makes it odd
    function automatic logic parity_of(input logic [`UART_DATA_BITS-1:0] d);
        int ones;
        ones = $countones(d);
        if (PAR == PARITY_ODD)
            return (ones % 2) == 0;
        return (ones % 2) == 1;
    endfunction

    function automatic uart_char_t make_char(input logic [`UART_DATA_BITS-1:0] d,
                                             input logic pe, input logic fe);
        uart_char_t c;
        c.data       = d;
        c.parity_err = pe;
        c.frame_err  = fe;
        return c;
    endfunction

    task automatic send_char(input logic [`UART_DATA_BITS-1:0] d, input logic keep);
        int n;
        n = 0;
        while (!tx_ready && n < 2 * FRAME)
        begin
            tick();
            n++;
        end
        if (!tx_ready)
            report_fail("tx_ready never returned high");
        tx_data  = d;
        tx_valid = 1'b1;
        if (keep)
            exp_q.push_back(make_char(d, 1'b0, 1'b0));
        tick();                                // Transfer on this edge
        tx_valid = 1'b0;
    endtask

    task automatic bang_frame(input logic [`UART_DATA_BITS-1:0] d, input logic flip_par,
                              input logic stop_bit);
        bb_line = 1'b0;
        wait_cycles(B);
        for (int i = 0; i < `UART_DATA_BITS; i++)
        begin
            bb_line = d[i];                    // LSB first
            wait_cycles(B);
        end
        if (PAR != PARITY_NONE)
        begin
            bb_line = parity_of(d) ^ flip_par;
            wait_cycles(B);
        end
        bb_line = stop_bit;
        wait_cycles(B);
        bb_line = 1'b1;
    endtask

    task automatic wait_drained(input string what);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 2 * FRAME)
        begin
            tick();
            n++;
        end
        if (exp_q.size() != 0)
        begin
            $display("timeout in %s: %0d characters never arrived", what, exp_q.size());
            err_count++;
            exp_q.delete();
        end
    endtask

    task automatic end_test(input string name);
        if (err_count == test_errs)
        begin
            pass_count++;
            $display("%-20s passed", name);
        end
        else
        begin
            fail_count++;
            $display("%-20s failed with %0d errors", name, err_count - test_errs);
        end
        test_errs = err_count;
    endtask

    // Pops are decided at the negedge, where inputs and outputs are settled
    always @(negedge clk)
    begin : rx_monitor
        uart_char_t exp;
        if (!rst)
        begin
            if (rx_overrun)
                overrun_count++;
            if (rx_valid && rx_ready)
            begin
                if (exp_q.size() == 0)
                    report_fail($sformatf("unexpected character %h", rx_char));
                else
                begin
                    exp = exp_q.pop_front();
                    assert (rx_char == exp)
                        else report_fail($sformatf("rx_char %h, expected %h", rx_char, exp));
                end
            end
        end
    end

    a_ready_mark: assert property (@(posedge clk) disable iff (rst) tx_ready |-> tx)
        else report_fail("tx low while tx_ready high");

    a_overrun_pulse: assert property (@(posedge clk) disable iff (rst)
        rx_overrun |=> !rx_overrun)
        else report_fail("rx_overrun longer than one cycle");

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////
    initial
    begin
        logic [`UART_DATA_BITS-1:0] b;
        int                         n;
        int                         base;
        rst = 1'b1;
        tx_data = '0;
        tx_valid = 1'b0;
        rx_ready = 1'b1;
        bb_line = 1'b1;
        loopback = 1'b1;
        rnd_state = 32'hb57a1c2c;
        err_count = 0;
        test_errs = 0;
        pass_count = 0;
        fail_count = 0;
        overrun_count = 0;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        // 1 Reset state
        tick();
        assert (tx === 1'b1) else report_fail("tx not high after reset");
        assert (tx_ready === 1'b1) else report_fail("tx_ready not high after reset");
        assert (rx_valid === 1'b0) else report_fail("rx_valid set after reset");
        assert (rx_overrun === 1'b0) else report_fail("rx_overrun set after reset");
        end_test("reset state");

        // 2 Transmit framing, sampled mid-bit
        b = next_byte();
        send_char(b, 1'b1);
        n = 0;
        while (tx && n < 4 * B)
        begin
            tick();
            n++;
        end
        wait_cycles(B / 2);
        assert (tx == 1'b0) else report_fail("start bit not low");
        for (int i = 0; i < `UART_DATA_BITS; i++)
        begin
            wait_cycles(B);
            assert (tx == b[i]) else report_fail($sformatf("data bit %0d wrong", i));
            assert (!tx_ready) else report_fail("tx_ready high inside frame");
        end
        if (PAR != PARITY_NONE)
        begin
            wait_cycles(B);
            assert (tx == parity_of(b)) else report_fail("parity bit wrong");
        end
        wait_cycles(B);
        assert (tx == 1'b1) else report_fail("stop bit not high");
        assert (!tx_ready) else report_fail("tx_ready high during stop bit");
        wait_drained("framing test");
        end_test("transmit framing");

        // 3 Back-to-back loopback
        for (int i = 0; i < 20; i++)
            send_char(next_byte(), 1'b1);
        wait_drained("loopback test");
        end_test("loopback data");

        // 4 Inverted parity bit on the bit-banged line
        loopback = 1'b0;
        b = next_byte();
        exp_q.push_back(make_char(b, PAR != PARITY_NONE, 1'b0));
        bang_frame(b, 1'b1, 1'b1);
        wait_drained("parity error test");
        end_test("parity error");

        // 5 Stop bit low, then one idle bit time
        b = next_byte();
        exp_q.push_back(make_char(b, 1'b0, 1'b1));
        bang_frame(b, 1'b0, 1'b0);
        wait_cycles(B);
        wait_drained("framing error test");
        end_test("framing error");

        // 6 FIFO overflow with the reader stalled
        loopback = 1'b1;
        rx_ready = 1'b0;
        base = overrun_count;
        for (int i = 0; i < DEPTH + 3; i++)
            send_char(next_byte(), i < DEPTH);
        n = 0;
        while (overrun_count - base < 3 && n < 3 * FRAME)
        begin
            tick();
            n++;
        end
        wait_cycles(FRAME);
        assert (overrun_count - base == 3)
            else report_fail($sformatf("%0d overrun pulses, expected 3", overrun_count - base));
        rx_ready = 1'b1;
        wait_drained("overflow drain");
        wait_cycles(4);
        assert (!rx_valid) else report_fail("FIFO held more characters than its depth");
        end_test("overflow");

        $display("%0d tests passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && err_count == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* design/uart_core.sv */
////////////////////////////////////////
// UART core top level
// Transmitter, receiver and receive FIFO
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "uart_cfg.svh"

module uart_core (
    input  logic                       clk,
    input  logic                       rst,
    // Transmit handshake
    input  logic [`UART_DATA_BITS-1:0] tx_data,
    input  logic                       tx_valid,
    output logic                       tx_ready,
    // Serial lines
    output logic                       tx,
    input  logic                       rx,
    // Receive handshake
    output uart_pkg::uart_char_t       rx_char,
    output logic                       rx_valid,
    input  logic                       rx_ready,
    output logic                       rx_overrun
);
    import uart_pkg::*;

    uart_char_t rx_char_w;                     // Deframer to FIFO
    logic       rx_strobe_w;

    uart_tx tx_i (
        .clk      (clk),
        .rst      (rst),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .tx       (tx)
    );

    uart_rx rx_i (
        .clk         (clk),
        .rst         (rst),
        .rx          (rx),
        .char_out    (rx_char_w),
        .char_strobe (rx_strobe_w)
    );

    uart_rx_fifo #(
        .DEPTH (`UART_FIFO_DEPTH)
    ) fifo_i (
        .clk         (clk),
        .rst         (rst),
        .char_in     (rx_char_w),
        .char_strobe (rx_strobe_w),
        .rx_char     (rx_char),
        .rx_valid    (rx_valid),
        .rx_ready    (rx_ready),
        .rx_overrun  (rx_overrun)
    );

endmodule

`default_nettype wire

/* design/uart_rx_fifo.sv */
////////////////////////////////////////
// Receive character FIFO
// Show-ahead buffer, drops and flags
// characters arriving while full
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module uart_rx_fifo #(
    parameter int unsigned DEPTH = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  uart_pkg::uart_char_t char_in,
    input  logic                 char_strobe,
    output uart_pkg::uart_char_t rx_char,
    output logic                 rx_valid,
    input  logic                 rx_ready,
    output logic                 rx_overrun
);
    import uart_pkg::*;

    localparam int unsigned AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = AW + 1;

    uart_char_t       mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push;
    logic             pop;

    assign full     = (count == CNT_W'(DEPTH));
    assign push     = char_strobe && !full;
    assign pop      = rx_valid && rx_ready;
    assign rx_valid = (count != '0);
    assign rx_char  = mem[rd_ptr];             // Head shown ahead

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= char_in;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            rx_overrun <= 1'b0;
        end
        else
        begin
            rx_overrun <= char_strobe && full;     // One pulse per lost character
            if (push)
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;         // Both or neither
            endcase
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (rst)
        count <= CNT_W'(DEPTH))
        else $error("FIFO occupancy above depth");

endmodule

`default_nettype wire

/* design/uart_rx.sv */
////////////////////////////////////////
// UART receiver
// Synchronizes the line, samples mid-bit
// and flags parity and framing errors
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "uart_cfg.svh"

module uart_rx (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rx,
    output uart_pkg::uart_char_t char_out,
    output logic                 char_strobe
);
    import uart_pkg::*;

    localparam int unsigned  CLKS     = `UART_CLKS_PER_BIT;
    localparam int unsigned  HALF     = CLKS / 2;
    localparam int unsigned  CNT_W    = $clog2(CLKS);
    localparam int unsigned  IDX_W    = $clog2(`UART_DATA_BITS);
    localparam uart_parity_e PAR_MODE = `UART_PARITY;

    uart_rx_state_e             state;
    logic                       rx_meta;
    logic                       rx_sync;
    logic                       rx_prev;      // For start edge detection
    logic [CNT_W-1:0]           bit_cnt;
    logic [IDX_W-1:0]           bit_idx;
    logic [`UART_DATA_BITS-1:0] shreg;
    logic                       par_acc;      // Running XOR of data bits
    logic                       par_err;
    logic                       sample;

    // Half a bit to confirm the start, then one full bit per sample
    assign sample = (state == RX_START) ? (bit_cnt == CNT_W'(HALF - 1))
                                        : (bit_cnt == CNT_W'(CLKS - 1));

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end
        else
        begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst || state == RX_IDLE || sample)
            bit_cnt <= '0;
        else
            bit_cnt <= bit_cnt + 1'b1;
    end

    ////////////////////////////////////////
    // Deframer control
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state       <= RX_IDLE;
            bit_idx     <= '0;
            char_strobe <= 1'b0;
        end
        else
        begin
            char_strobe <= 1'b0;
            case (state)
                RX_IDLE:
                begin
                    if (rx_prev && !rx_sync)
                        state <= RX_START;
                end
                RX_START:
                begin
                    if (sample)
                    begin
                        state   <= rx_sync ? RX_IDLE : RX_DATA;   // High here is a glitch
                        bit_idx <= '0;
                    end
                end
                RX_DATA:
                begin
                    if (sample)
                    begin
                        if (bit_idx == IDX_W'(`UART_DATA_BITS - 1))
                            state <= (PAR_MODE == PARITY_NONE) ? RX_STOP : RX_PARITY;
                        else
                            bit_idx <= bit_idx + 1'b1;
                    end
                end
                RX_PARITY:
                begin
                    if (sample)
                        state <= RX_STOP;
                end
                RX_STOP:
                begin
                    if (sample)
                    begin
                        state       <= RX_IDLE;
                        char_strobe <= 1'b1;      // Stop bit midpoint
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Data path, sampled at bit midpoints
    always_ff @(posedge clk)
    begin
        if (sample)
        begin
            case (state)
                RX_START:
                begin
                    par_acc <= 1'b0;
                    par_err <= 1'b0;
                end
                RX_DATA:
                begin
                    shreg   <= {rx_sync, shreg[`UART_DATA_BITS-1:1]};  // LSB arrives first
                    par_acc <= par_acc ^ rx_sync;
                end
                RX_PARITY:
                    par_err <= (PAR_MODE == PARITY_ODD) ? ~(par_acc ^ rx_sync)
                                                        : (par_acc ^ rx_sync);
                RX_STOP:
                begin
                    char_out.data       <= shreg;
                    char_out.parity_err <= par_err;
                    char_out.frame_err  <= ~rx_sync;
                end
                default: ;
            endcase
        end
    end

    a_strobe_single: assert property (@(posedge clk) disable iff (rst)
        char_strobe |=> !char_strobe)
        else $error("char_strobe held for two cycles");

endmodule

`default_nettype wire

/* design/uart_tx.sv */
////////////////////////////////////////
// UART transmitter
// Takes one character per valid/ready transfer
// and sends start, data LSB first, parity, stop
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "uart_cfg.svh"

module uart_tx (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`UART_DATA_BITS-1:0] tx_data,
    input  logic                       tx_valid,
    output logic                       tx_ready,
    output logic                       tx
);
    import uart_pkg::*;

    localparam int unsigned  CLKS     = `UART_CLKS_PER_BIT;
    localparam int unsigned  CNT_W    = $clog2(CLKS);
    localparam int unsigned  IDX_W    = $clog2(`UART_DATA_BITS);
    localparam uart_parity_e PAR_MODE = `UART_PARITY;

    uart_tx_state_e             state;
    logic [CNT_W-1:0]           bit_cnt;      // Clocks into the current bit
    logic [IDX_W-1:0]           bit_idx;      // Data bit on the line
    logic [`UART_DATA_BITS-1:0] data_q;
    logic                       bit_end;
    logic                       par_bit;

    assign bit_end  = (bit_cnt == CNT_W'(CLKS - 1));
    assign tx_ready = (state == TX_IDLE);
    assign par_bit  = (PAR_MODE == PARITY_ODD) ? ~^data_q : ^data_q;

    always_ff @(posedge clk)
    begin
        if (tx_valid && tx_ready)
            data_q <= tx_data;                // Held for the whole frame
    end

    // Bit period timer, idle while waiting for a character
    always_ff @(posedge clk)
    begin
        if (rst || state == TX_IDLE || bit_end)
            bit_cnt <= '0;
        else
            bit_cnt <= bit_cnt + 1'b1;
    end

    ////////////////////////////////////////
    // Frame sequencer
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= TX_IDLE;
            tx      <= 1'b1;
            bit_idx <= '0;
        end
        else
        begin
            case (state)
                TX_IDLE:
                begin
                    if (tx_valid)
                    begin
                        state <= TX_START;
                        tx    <= 1'b0;          // Start bit from the next cycle
                    end
                end
                TX_START:
                begin
                    if (bit_end)
                    begin
                        state   <= TX_DATA;
                        tx      <= data_q[0];
                        bit_idx <= '0;
                    end
                end
                TX_DATA:
                begin
                    if (bit_end)
                    begin
                        if (bit_idx == IDX_W'(`UART_DATA_BITS - 1))
                        begin
                            if (PAR_MODE == PARITY_NONE)
                            begin
                                state <= TX_STOP;
                                tx    <= 1'b1;
                            end
                            else
                            begin
                                state <= TX_PARITY;
                                tx    <= par_bit;
                            end
                        end
                        else
                        begin
                            bit_idx <= bit_idx + 1'b1;
                            tx      <= data_q[bit_idx + 1'b1];
                        end
                    end
                end
                TX_PARITY:
                begin
                    if (bit_end)
                    begin
                        state <= TX_STOP;
                        tx    <= 1'b1;
                    end
                end
                TX_STOP:
                begin
                    if (bit_end)
                        state <= TX_IDLE;       // Ready again next cycle
                end
                default:
                begin
                    state <= TX_IDLE;
                    tx    <= 1'b1;
                end
            endcase
        end
    end

    // Line must rest at mark level between frames
    a_idle_mark: assert property (@(posedge clk) disable iff (rst)
        state == TX_IDLE |-> tx)
        else $error("tx low while transmitter idle");

endmodule

`default_nettype wire

/* design/uart_pkg.sv */
////////////////////////////////////////
// UART shared types
// Parity modes, FSM states and the
// received character record
////////////////////////////////////////
`default_nettype none

`include "uart_cfg.svh"

package uart_pkg;

    typedef enum logic [1:0] {
        PARITY_NONE,
        PARITY_EVEN,
        PARITY_ODD
    } uart_parity_e;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_PARITY,
        TX_STOP
    } uart_tx_state_e;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } uart_rx_state_e;

    // One received character with its line errors
    typedef struct packed {
        logic [`UART_DATA_BITS-1:0] data;
        logic                       parity_err;   // Parity bit mismatch
        logic                       frame_err;    // Stop bit sampled low
    } uart_char_t;

endpackage

`default_nettype wire

/* design/uart_cfg.svh */
////////////////////////////////////////
// UART configuration
// Clock, bit rate, character format and
// receive buffer depth, fixed at compile time
////////////////////////////////////////
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// Timing
`define UART_CLK_FREQ      50000000                          // Hz
`define UART_BAUD          3125000                           // Bit/s
`define UART_CLKS_PER_BIT  (`UART_CLK_FREQ / `UART_BAUD)     // 16 clocks per bit

// Character format
`define UART_DATA_BITS     8
`define UART_PARITY        uart_pkg::PARITY_EVEN             // None, even or odd

// Receive side
`define UART_FIFO_DEPTH    16                                // Power of two

`endif
